// ==== opl3_consts.svh ====
`ifndef OPL3_CONSTS_SVH
`define OPL3_CONSTS_SVH

// Phase accumulator and the phase bits handed to the waveform stage.
`define PHASE_ACC_WIDTH 20
`define PHASE_OUT_WIDTH 8

// Signed output sample.
`define SAMPLE_WIDTH 16

// Quarter-wave table entries.
`define SINE_DEPTH 64

// Clock cycles per step pulse.
`define SAMPLE_DIV 64

// Clock cycles per half period of the I2S bit clock.
`define SCLK_DIV 2

// Transmitter buffer depth, equal to the initial credit count.
`define SAMPLE_CREDITS 2

`endif

// ==== opl3_pkg.sv ====
`include "opl3_consts.svh"

package opl3_pkg;

    // Operator register 0x20.
    typedef struct packed {
        logic       am;
        logic       vib;
        logic       egt;
        logic       ksr;
        logic [3:0] mult;
    } reg_op_t;

    // Register 0xB0, laid out as on the OPL3.
    typedef struct packed {
        logic [1:0] rsvd;
        logic       key_on;
        logic [2:0] block;
        logic [1:0] fnum_hi;
    } reg_b0_t;

    // One data byte, read according to the address it goes to.
    typedef union packed {
        logic [7:0] fnum_lo;
        reg_b0_t    b0;
        reg_op_t    op;
    } reg_data_u;

    typedef struct packed {
        logic [7:0] addr;
        reg_data_u  data;
    } reg_wr_t;

    typedef struct packed {
        logic                            valid;
        logic signed [`SAMPLE_WIDTH-1:0] sample;
    } sample_xfer_t;

endpackage

// ==== sample_clk_div.sv ====
`include "opl3_consts.svh"

module sample_clk_div (
    input  logic clk,
    input  logic rst,
    output logic step
);

    localparam int CNT_W = $clog2(`SAMPLE_DIV);

    logic [CNT_W-1:0] cnt;

    always_ff @(posedge clk) begin
        if (rst) begin
            cnt  <= '0;
            step <= 1'b0;
        end else begin
            if (cnt == CNT_W'(`SAMPLE_DIV - 1)) begin
                cnt <= '0; // Wrap at the end of the sample period.
            end else begin
                cnt <= cnt + 1'b1;
            end
            step <= (cnt == CNT_W'(`SAMPLE_DIV - 1));
        end
    end

    // Downstream logic counts one advance per pulse.
    a_step_single : assert property (
        @(posedge clk) disable iff (rst)
        step |=> !step
    );

endmodule

// ==== phase_gen.sv ====
`include "opl3_consts.svh"

module phase_gen import opl3_pkg::*; (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        step,
    input  logic                        phase_ready,
    input  logic                        reg_wr_en,
    input  reg_wr_t                     reg_wr,
    output logic                        phase_valid,
    output logic [`PHASE_OUT_WIDTH-1:0] phase,
    output logic                        key_on
);

    localparam int ACC_W = `PHASE_ACC_WIDTH;
    localparam logic [7:0] ADDR_OP = 8'h20;
    localparam logic [7:0] ADDR_FNUM_LO = 8'hA0;
    localparam logic [7:0] ADDR_B0 = 8'hB0;

    logic [9:0]       fnum;
    logic [2:0]       block;
    logic [3:0]       mult;
    logic             key_on_r;
    logic [4:0]       mult_x2;
    logic [16:0]      fnum_shift;
    logic [20:0]      prod;
    logic [ACC_W-1:0] inc;
    logic [ACC_W-1:0] acc;
    logic             accept;

    // Voice registers.
    always_ff @(posedge clk) begin
        if (rst) begin
            fnum     <= '0;
            block    <= '0;
            mult     <= '0;
            key_on_r <= 1'b0;
        end else if (reg_wr_en) begin
            case (reg_wr.addr)
                ADDR_OP:      mult <= reg_wr.data.op.mult;
                ADDR_FNUM_LO: fnum[7:0] <= reg_wr.data.fnum_lo;
                ADDR_B0: begin
                    key_on_r  <= reg_wr.data.b0.key_on;
                    block     <= reg_wr.data.b0.block;
                    fnum[9:8] <= reg_wr.data.b0.fnum_hi;
                end
                default: ; // Other addresses are ignored.
            endcase
        end
    end

    // Multiplier in half steps.
    always_comb begin
        case (mult)
            4'd0:         mult_x2 = 5'd1;
            4'd11:        mult_x2 = 5'd20;
            4'd12, 4'd13: mult_x2 = 5'd24;
            4'd14, 4'd15: mult_x2 = 5'd30;
            default:      mult_x2 = {mult, 1'b0};
        endcase
    end

    always_comb begin
        fnum_shift = 17'(fnum) << block;
        prod       = 21'(fnum_shift) * 21'(mult_x2);
        inc        = ACC_W'(prod >> 1); // Undo the half-step scaling.
    end

    // A step that finds the lookup stage busy is dropped.
    assign accept = step && phase_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            acc         <= '0;
            phase_valid <= 1'b0;
        end else begin
            phase_valid <= accept;
            if (accept) begin
                acc <= key_on_r ? acc + inc : '0; // Key off restarts from 0.
            end
        end
    end

    // Phase leaves before the add, so a fresh key-on starts at phase 0.
    always_ff @(posedge clk) begin
        if (accept) begin
            phase  <= acc[ACC_W-1 -: `PHASE_OUT_WIDTH];
            key_on <= key_on_r;
        end
    end

    // The lookup stage cannot stall, so it must still be free when a phase lands.
    a_valid_after_accept : assert property (
        @(posedge clk) disable iff (rst)
        phase_valid |-> phase_ready
    );

endmodule

// ==== wave_gen.sv ====
`include "opl3_consts.svh"

module wave_gen import opl3_pkg::*; (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        phase_valid,
    input  logic [`PHASE_OUT_WIDTH-1:0] phase,
    input  logic                        key_on,
    output logic                        phase_ready,
    input  logic                        credit_return,
    output sample_xfer_t                xfer
);

    localparam int IDX_W = $clog2(`SINE_DEPTH);
    localparam int CRED_W = $clog2(`SAMPLE_CREDITS + 1);

    logic [`SAMPLE_WIDTH-1:0] sine_rom [0:`SINE_DEPTH-1];

    logic [IDX_W-1:0]                idx;
    logic                            s1_valid;
    logic [`SAMPLE_WIDTH-1:0]        s1_mag;
    logic                            s1_sign;
    logic                            s1_key;
    logic                            s1_adv;
    logic                            out_full;
    logic signed [`SAMPLE_WIDTH-1:0] out_sample;
    logic [CRED_W-1:0]               credits;
    logic                            send;

    initial begin
        $readmemh("sine_quarter.hex", sine_rom);
    end

    // Second quarter runs the table backwards.
    assign idx = phase[6] ? ~phase[IDX_W-1:0] : phase[IDX_W-1:0];

    assign send        = out_full && (credits != '0);
    assign s1_adv      = s1_valid && (!out_full || send);
    assign phase_ready = !s1_valid;

    // Lookup stage.
    always_ff @(posedge clk) begin
        if (rst) begin
            s1_valid <= 1'b0;
        end else if (phase_valid) begin
            s1_valid <= 1'b1;
        end else if (s1_adv) begin
            s1_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (phase_valid) begin
            s1_mag  <= sine_rom[idx];
            s1_sign <= phase[`PHASE_OUT_WIDTH-1];
            s1_key  <= key_on;
        end
    end

    // Output register, drained against credits.
    always_ff @(posedge clk) begin
        if (rst) begin
            out_full <= 1'b0;
        end else if (s1_adv) begin
            out_full <= 1'b1;
        end else if (send) begin
            out_full <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (s1_adv) begin
            if (!s1_key) begin
                out_sample <= '0; // Silent while the key is off.
            end else if (s1_sign) begin
                out_sample <= -$signed(s1_mag);
            end else begin
                out_sample <= $signed(s1_mag);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            credits <= CRED_W'(`SAMPLE_CREDITS);
        end else begin
            case ({send, credit_return})
                2'b10:   credits <= credits - 1'b1;
                2'b01:   credits <= credits + 1'b1;
                default: credits <= credits; // Both or neither.
            endcase
        end
    end

    always_comb begin
        xfer.valid  = send;
        xfer.sample = out_sample;
    end

    // Returned credits can never outnumber the buffer slots.
    a_credit_bound : assert property (
        @(posedge clk) disable iff (rst)
        credits <= CRED_W'(`SAMPLE_CREDITS)
    );

endmodule

// ==== i2s_tx.sv ====
`include "opl3_consts.svh"

module i2s_tx import opl3_pkg::*; (
    input  logic         clk,
    input  logic         rst,
    input  sample_xfer_t xfer,
    output logic         credit_return,
    output logic         i2s_sclk,
    output logic         i2s_ws,
    output logic         i2s_sd
);

    localparam int DEPTH = `SAMPLE_CREDITS;
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);
    localparam int DIV_W = $clog2(`SCLK_DIV + 1);
    localparam int FRAME_W = 2 * `SAMPLE_WIDTH;

    logic signed [`SAMPLE_WIDTH-1:0] fifo_mem [0:DEPTH-1];

    logic [PTR_W-1:0]         wr_ptr;
    logic [PTR_W-1:0]         rd_ptr;
    logic [CNT_W-1:0]         fifo_count;
    logic                     push;
    logic                     pop;
    logic [DIV_W-1:0]         div_cnt;
    logic                     tick;
    logic                     fall;
    logic [4:0]               bit_cnt;
    logic [4:0]               next_bit;
    logic                     frame_start;
    logic [`SAMPLE_WIDTH-1:0] frame_sample;
    logic [FRAME_W-1:0]       shreg;

    assign tick        = (div_cnt == DIV_W'(`SCLK_DIV - 1));
    assign fall        = tick && i2s_sclk;
    assign next_bit    = bit_cnt + 1'b1;
    assign frame_start = fall && (bit_cnt == 5'd31);

    assign push = xfer.valid;
    assign pop  = frame_start && (fifo_count != '0);

    // Underrun sends silence.
    assign frame_sample = (fifo_count != '0) ? fifo_mem[rd_ptr] : '0;

    always_ff @(posedge clk) begin
        if (push) begin
            fifo_mem[wr_ptr] <= xfer.sample;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr        <= '0;
            rd_ptr        <= '0;
            fifo_count    <= '0;
            credit_return <= 1'b0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   fifo_count <= fifo_count + 1'b1;
                2'b01:   fifo_count <= fifo_count - 1'b1;
                default: fifo_count <= fifo_count;
            endcase
            credit_return <= pop; // Slot freed, hand a credit back.
        end
    end

    // Bit clock.
    always_ff @(posedge clk) begin
        if (rst) begin
            div_cnt  <= '0;
            i2s_sclk <= 1'b0;
        end else if (tick) begin
            div_cnt  <= '0;
            i2s_sclk <= ~i2s_sclk;
        end else begin
            div_cnt <= div_cnt + 1'b1;
        end
    end

    // Serializer, everything moves on the falling edge.
    always_ff @(posedge clk) begin
        if (rst) begin
            bit_cnt <= 5'd31; // First falling edge opens a frame.
            i2s_ws  <= 1'b0;
            i2s_sd  <= 1'b0;
            shreg   <= '0;
        end else if (fall) begin
            bit_cnt <= next_bit;
            i2s_ws  <= next_bit[4]; // Right word in the upper half.
            i2s_sd  <= shreg[FRAME_W-1]; // One bit behind ws.
            if (frame_start) begin
                shreg <= {frame_sample, frame_sample};
            end else begin
                shreg <= shreg << 1;
            end
        end
    end

    // Sender must hold off without a free slot.
    a_no_overflow : assert property (
        @(posedge clk) disable iff (rst)
        xfer.valid |-> (fifo_count < CNT_W'(DEPTH))
    );

endmodule

// ==== opl3_voice.sv ====
`include "opl3_consts.svh"

module opl3_voice import opl3_pkg::*; (
    input  logic    clk,
    input  logic    rst,
    input  logic    reg_wr_en,
    input  reg_wr_t reg_wr,
    output logic    i2s_sclk,
    output logic    i2s_ws,
    output logic    i2s_sd
);

    logic                        step;
    logic                        phase_ready;
    logic                        phase_valid;
    logic [`PHASE_OUT_WIDTH-1:0] phase;
    logic                        key_on;
    sample_xfer_t                xfer;
    logic                        credit_return;

    sample_clk_div sample_clk_div_i (
        .clk  (clk),
        .rst  (rst),
        .step (step)
    );

    phase_gen phase_gen_i (
        .clk         (clk),
        .rst         (rst),
        .step        (step),
        .phase_ready (phase_ready),
        .reg_wr_en   (reg_wr_en),
        .reg_wr      (reg_wr),
        .phase_valid (phase_valid),
        .phase       (phase),
        .key_on      (key_on)
    );

    wave_gen wave_gen_i (
        .clk           (clk),
        .rst           (rst),
        .phase_valid   (phase_valid),
        .phase         (phase),
        .key_on        (key_on),
        .phase_ready   (phase_ready),
        .credit_return (credit_return),
        .xfer          (xfer)
    );

    // Same sample on both channels.
    i2s_tx i2s_tx_i (
        .clk           (clk),
        .rst           (rst),
        .xfer          (xfer),
        .credit_return (credit_return),
        .i2s_sclk      (i2s_sclk),
        .i2s_ws        (i2s_ws),
        .i2s_sd        (i2s_sd)
    );

endmodule

// ==== tb_opl3_voice.sv ====
`include "opl3_consts.svh"

module tb_opl3_voice import opl3_pkg::*; ;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int NUM_ROWS = 6;
    localparam int INIT_FRAMES = 4;
    localparam int DRAIN_FRAMES = 8;
    localparam int FRAME_CYCLES = 4 * `SCLK_DIV * `SAMPLE_WIDTH;

    typedef struct packed {
        logic [3:0] mult;
        logic [9:0] fnum;
        logic [2:0] block;
        logic       key_on;
        int         frames;
    } row_t;

    logic    clk;
    logic    rst;
    logic    reg_wr_en;
    reg_wr_t reg_wr;
    logic    i2s_sclk;
    logic    i2s_ws;
    logic    i2s_sd;

    row_t        rows [NUM_ROWS];
    logic [15:0] sine_ref [0:`SINE_DEPTH-1];
    logic [31:0] frame_q [$]; // Left word in the upper half.
    int          next_frame;
    int          error_count;
    int          check_count;
    int          cycle_count;
    int          cycle_limit;

    logic        ws_prev;
    logic [15:0] word_sh;
    logic [15:0] left_word;

    opl3_voice opl3_voice_i (
        .clk       (clk),
        .rst       (rst),
        .reg_wr_en (reg_wr_en),
        .reg_wr    (reg_wr),
        .i2s_sclk  (i2s_sclk),
        .i2s_ws    (i2s_ws),
        .i2s_sd    (i2s_sd)
    );

    initial begin
        clk = 1'b0;
    end

    always #50 clk = ~clk;

    // I2S receiver. A ws change marks the LSB of the word just sent.
    always @(posedge i2s_sclk) begin
        logic [15:0] word;
        word = {word_sh[14:0], i2s_sd};
        word_sh <= word;
        ws_prev <= i2s_ws;
        if (i2s_ws != ws_prev) begin
            if (ws_prev == 1'b0) begin
                left_word <= word;
            end else begin
                frame_q.push_back({left_word, word});
            end
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_limit != 0 && cycle_count >= cycle_limit) begin
            $display("Timeout: no result after %0d clock cycles.", cycle_count);
            $display("TESTS FAILED");
            $finish;
        end
    end

    function automatic logic [4:0] mult_x2_of(input logic [3:0] mult);
        case (mult)
            4'd0:         return 5'd1;
            4'd11:        return 5'd20;
            4'd12, 4'd13: return 5'd24;
            4'd14, 4'd15: return 5'd30;
            default:      return 5'(2 * mult);
        endcase
    endfunction

    function automatic logic [19:0] increment_of(input row_t r);
        longint full;
        full = (longint'(r.fnum) << r.block) * longint'(mult_x2_of(r.mult));
        return 20'(full >> 1);
    endfunction

    function automatic logic [15:0] sample_of(input logic [`PHASE_ACC_WIDTH-1:0] acc);
        logic [7:0]  ph;
        logic [5:0]  idx;
        logic [15:0] mag;
        ph  = acc[`PHASE_ACC_WIDTH-1 -: 8];
        idx = ph[6] ? ~ph[5:0] : ph[5:0]; // Falling quarter.
        mag = sine_ref[idx];
        return ph[7] ? 16'(-mag) : mag;
    endfunction

    task automatic check_value(input logic [31:0] got, input logic [31:0] exp,
                               input string what);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("error: time %0t: %s, got %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic write_reg(input logic [7:0] addr, input logic [7:0] data);
        @(posedge clk);
        reg_wr_en   <= 1'b1;
        reg_wr.addr <= addr;
        reg_wr.data <= data;
        @(posedge clk);
        reg_wr_en <= 1'b0;
    endtask

    task automatic wait_frames(input int n);
        int target;
        target = next_frame + n;
        while (frame_q.size() < target) begin
            @(posedge clk);
        end
    endtask

    task automatic fill_rows();
        rows[0] = '{mult: 4'd1,  fnum: 10'h200, block: 3'd4, key_on: 1'b1, frames: 40};
        rows[1] = '{mult: 4'd0,  fnum: 10'h155, block: 3'd5, key_on: 1'b1, frames: 32};
        rows[2] = '{mult: 4'd11, fnum: 10'h0A3, block: 3'd3, key_on: 1'b1, frames: 32};
        rows[3] = '{mult: 4'd13, fnum: 10'h2F1, block: 3'd2, key_on: 1'b0, frames: 16};
        rows[4] = '{mult: 4'd13, fnum: 10'h2F1, block: 3'd2, key_on: 1'b1, frames: 32};
        rows[5] = '{mult: 4'd15, fnum: 10'h3FF, block: 3'd7, key_on: 1'b1, frames: 32};
    endtask

    // The three voice registers, then random bytes to unused addresses.
    task automatic apply_row(input row_t r);
        logic [7:0] junk_addr [4];
        junk_addr = '{8'h21, 8'h40, 8'hA1, 8'hB1};
        write_reg(8'h20, {4'b0000, r.mult});
        write_reg(8'hA0, r.fnum[7:0]);
        write_reg(8'hB0, {2'b00, r.key_on, r.block, r.fnum[9:8]});
        foreach (junk_addr[i]) begin
            write_reg(junk_addr[i], 8'($urandom));
        end
    endtask

    task automatic key_off_drain(input row_t r);
        logic [31:0] fr;
        write_reg(8'hB0, {2'b00, 1'b0, r.block, r.fnum[9:8]});
        wait_frames(DRAIN_FRAMES);
        for (int i = DRAIN_FRAMES - 3; i < DRAIN_FRAMES; i++) begin
            fr = frame_q[next_frame + i];
            check_value(fr, 32'h0, "frame after key off not silent");
        end
        next_frame += DRAIN_FRAMES;
    endtask

    task automatic capture_row(input int row_idx, input row_t r);
        logic [19:0] acc;
        logic [19:0] inc;
        logic [31:0] fr;
        int          nonzero;
        acc     = '0;
        inc     = increment_of(r);
        nonzero = 0;
        wait_frames(r.frames);
        for (int i = 0; i < r.frames; i++) begin
            fr = frame_q[next_frame + i];
            check_value(32'(fr[15:0]), 32'(fr[31:16]),
                        $sformatf("row %0d right word", row_idx));
            if (!r.key_on) begin
                check_value(32'(fr[31:16]), 32'h0,
                            $sformatf("row %0d key off word", row_idx));
            end else if (fr[31:16] != 16'h0) begin
                check_value(32'(fr[31:16]), 32'(sample_of(acc)),
                            $sformatf("row %0d sample %0d", row_idx, nonzero));
                acc = acc + inc;
                nonzero++;
            end
        end
        if (r.key_on) begin
            check_value(32'(nonzero >= r.frames - DRAIN_FRAMES), 32'd1,
                        $sformatf("row %0d too few samples (%0d)", row_idx, nonzero));
        end
        next_frame += r.frames;
    endtask

    initial begin
        int total_frames;
        rst         = 1'b1;
        reg_wr_en   = 1'b0;
        reg_wr      = '0;
        ws_prev     = 1'b0;
        word_sh     = '0;
        left_word   = '0;
        next_frame  = 0;
        error_count = 0;
        check_count = 0;
        cycle_count = 0;
        void'($urandom(32'hc508));
        $readmemh("sine_quarter.hex", sine_ref);
        fill_rows();

        total_frames = INIT_FRAMES;
        foreach (rows[i]) begin
            total_frames += DRAIN_FRAMES + rows[i].frames;
        end
        cycle_limit = total_frames * FRAME_CYCLES + 2000;

        repeat (3) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);
        check_value(32'(i2s_ws), 32'h0, "ws after reset");
        check_value(32'(i2s_sd), 32'h0, "sd after reset");

        // Silence until the first key on.
        wait_frames(INIT_FRAMES);
        for (int i = 0; i < INIT_FRAMES; i++) begin
            check_value(frame_q[i], 32'h0, "frame before key on");
        end
        next_frame = INIT_FRAMES;

        foreach (rows[i]) begin
            key_off_drain(rows[i]);
            apply_row(rows[i]);
            capture_row(i, rows[i]);
        end

        $display("Checks run: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

// ==== sine_quarter.hex ====
// One 16-bit hex magnitude per line, quarter sine at (i + 0.5) * pi / 128, i = 0..63.
0192
04B6
07D9
0AFB
0E1C
113A
1455
176E
1A82
1D93
209F
23A6
26A8
29A3
2C99
2F87
326E
354D
3824
3AF2
3DB8
4073
4325
45CD
4869
4AFB
4D81
4FFB
5268
54C9
571D
5964
5B9C
5DC7
5FE3
61F0
63EE
65DD
67BC
698B
6B4A
6CF8
6E96
7022
719D
7307
745F
75A5
76D8
77FA
7909
7A05
7AEE
7BC5
7C88
7D39
7DD5
7E5F
7ED5
7F37
7F86
7FC1
7FE9
7FFD

// ==== tb.f ====
+incdir+.
opl3_pkg.sv
sample_clk_div.sv
phase_gen.sv
wave_gen.sv
i2s_tx.sv
opl3_voice.sv
tb_opl3_voice.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the opl3_voice testbench with Verilator.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f tb.f --top-module tb_opl3_voice \
    -Mdir obj_dir -o sim_tb
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "TESTS PASSED" sim.log; then
    exit 0
fi
echo "Pass message not found in sim.log"
exit 1
